// File: hdl/x25519_pkg.sv
package x25519_pkg;

    localparam int FIELD_W = 255;
    localparam int PROD_W  = 2 * FIELD_W;

    typedef logic [FIELD_W-1:0] felem_t;

    // p = 2^255 - 19
    localparam felem_t PRIME = {{(FIELD_W - 5){1'b1}}, 5'b01101};

    // 2^255 folds back as 19
    localparam logic [4:0] FOLD_C = 5'd19;

    // (486662 + 2) / 4
    localparam felem_t A24 = FIELD_W'(121666);

    typedef struct packed {
        felem_t hi;
        felem_t lo;
    } prod_hl_t;

    // Full product, flat or split at bit 255
    typedef union packed {
        logic [PROD_W-1:0] flat;
        prod_hl_t          hl;
    } prod_u;

endpackage

// File: hdl/field_if.sv
`timescale 1ns/1ps

// ============================================================
// Multiplier
// ============================================================
interface mul_if;
    logic               start;
    x25519_pkg::felem_t a;
    x25519_pkg::felem_t b;
    x25519_pkg::prod_u  product;
    logic               done;

    modport ctrl (output start, a, b, input product, done);
    modport target (input start, a, b, output product, done);
endinterface

// ============================================================
// Reducer
// ============================================================
interface red_if;
    logic               start;
    x25519_pkg::prod_u  value;
    x25519_pkg::felem_t result;
    logic               done;

    modport ctrl (output start, value, input result, done);
    modport target (input start, value, output result, done);
endinterface

// Combinational add/sub, no handshake
interface addsub_if;
    x25519_pkg::felem_t a;
    x25519_pkg::felem_t b;
    logic               sub;
    x25519_pkg::felem_t result;

    modport ctrl (output a, b, sub, input result);
    modport target (input a, b, sub, output result);
endinterface

// File: hdl/field_mul.sv
`timescale 1ns/1ps

module field_mul #(
    parameter int DIGIT_W = 5
) (
    input logic   clk,
    input logic   reset,
    mul_if.target mul
);

    localparam int FIELD_W = x25519_pkg::FIELD_W;
    localparam int PROD_W  = x25519_pkg::PROD_W;
    localparam int PART_W  = FIELD_W + DIGIT_W;
    localparam int NDIG    = FIELD_W / DIGIT_W;
    localparam int CNT_W   = $clog2(NDIG + 1);

    x25519_pkg::felem_t a_q;
    x25519_pkg::felem_t b_q;
    logic [PROD_W-1:0]  acc;
    logic [PART_W-1:0]  partial;
    logic [CNT_W-1:0]   cnt;

    // a times the top digit of b, MSB first
    assign partial = PART_W'(a_q) * PART_W'(b_q[FIELD_W-1 -: DIGIT_W]);

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt      <= '0;
            mul.done <= 1'b0;
        end else begin
            mul.done <= 1'b0;
            if (mul.start) begin
                cnt <= CNT_W'(NDIG);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    mul.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul.start) begin
            a_q <= mul.a;
            b_q <= mul.b;
            acc <= '0;
        end else if (cnt != '0) begin
            acc <= (acc << DIGIT_W) + PROD_W'(partial);
            b_q <= b_q << DIGIT_W;
        end
    end

    assign mul.product.flat = acc;

endmodule

// File: hdl/field_reduce.sv
`timescale 1ns/1ps

module field_reduce (
    input logic   clk,
    input logic   reset,
    red_if.target red
);

    localparam int FIELD_W = x25519_pkg::FIELD_W;
    localparam int PROD_W  = x25519_pkg::PROD_W;

    x25519_pkg::prod_u  v;
    x25519_pkg::prod_u  fold;
    x25519_pkg::felem_t reduced;
    logic               active;
    logic               last;

    // lo + 19*hi, at most three passes from a full product
    assign fold.flat = {{FIELD_W{1'b0}}, v.hl.lo}
                     + PROD_W'(v.hl.hi) * PROD_W'(x25519_pkg::FOLD_C);

    // Nothing left above bit 255 after this pass
    assign last = (fold.hl.hi == '0);

    // Below 2^255 here, so one subtraction is enough
    assign reduced = (fold.hl.lo >= x25519_pkg::PRIME) ?
                     fold.hl.lo - x25519_pkg::PRIME : fold.hl.lo;

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            red.done <= 1'b0;
        end else begin
            red.done <= 1'b0;
            if (red.start) begin
                active <= 1'b1;
            end else if (active && last) begin
                active   <= 1'b0;
                red.done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (red.start) begin
            v <= red.value;
        end else if (active) begin
            v <= fold;
            if (last) begin
                red.result <= reduced;
            end
        end
    end

endmodule

// File: hdl/field_addsub.sv
`timescale 1ns/1ps

module field_addsub (
    addsub_if.target as
);

    localparam int FIELD_W = x25519_pkg::FIELD_W;

    logic [FIELD_W:0] sum;
    logic [FIELD_W:0] sum_m_p;
    logic             a_lt_b;

    assign sum     = {1'b0, as.a} + {1'b0, as.b};
    assign sum_m_p = sum - {1'b0, x25519_pkg::PRIME};
    assign a_lt_b  = (as.a < as.b);

    always_comb begin
        if (as.sub) begin
            // Wrap through p when the difference goes negative
            as.result = a_lt_b ? as.a + x25519_pkg::PRIME - as.b : as.a - as.b;
        end else if (sum >= {1'b0, x25519_pkg::PRIME}) begin
            as.result = sum_m_p[FIELD_W-1:0];
        end else begin
            as.result = sum[FIELD_W-1:0];
        end
    end

endmodule

// File: hdl/ladder_dbl_ctrl.sv
`timescale 1ns/1ps

module ladder_dbl_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  x25519_pkg::felem_t x_in,
    input  x25519_pkg::felem_t z_in,
    output x25519_pkg::felem_t x_out,
    output x25519_pkg::felem_t z_out,
    output logic               done,
    output logic               busy,
    mul_if.ctrl                mul,
    red_if.ctrl                red,
    addsub_if.ctrl             as
);

    localparam logic [3:0] S_IDLE   = 4'd0;
    localparam logic [3:0] S_SUM    = 4'd1;
    localparam logic [3:0] S_SS_MUL = 4'd2;
    localparam logic [3:0] S_SS_RED = 4'd3;
    localparam logic [3:0] S_DD_MUL = 4'd4;
    localparam logic [3:0] S_DD_RED = 4'd5;
    localparam logic [3:0] S_T      = 4'd6;
    localparam logic [3:0] S_X_MUL  = 4'd7;
    localparam logic [3:0] S_X_RED  = 4'd8;
    localparam logic [3:0] S_U_MUL  = 4'd9;
    localparam logic [3:0] S_U_RED  = 4'd10;
    localparam logic [3:0] S_Z_MUL  = 4'd11;
    localparam logic [3:0] S_Z_RED  = 4'd12;

    logic [3:0]         state;
    logic               mul_seen;
    logic               mul_ready;
    x25519_pkg::felem_t x_q;
    x25519_pkg::felem_t z_q;
    x25519_pkg::felem_t ss;
    x25519_pkg::felem_t dd;
    x25519_pkg::felem_t t;
    x25519_pkg::felem_t x_res;

    assign busy = (state != S_IDLE);

    // Multiplier done may land while a reduction is still pending
    assign mul_ready = mul.done | mul_seen;

    // ============================================================
    // Adder/subtractor operands
    // ============================================================
    always_comb begin
        as.a   = x_q;
        as.b   = z_q;
        as.sub = 1'b0;
        case (state)
            S_SS_MUL: as.sub = 1'b1;
            S_T: begin
                as.a   = ss;
                as.b   = dd;
                as.sub = 1'b1;
            end
            S_U_RED: begin
                as.a = red.result;
                as.b = dd;
            end
            default: as.sub = 1'b0;
        endcase
    end

    // ============================================================
    // Sequencer
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            mul_seen  <= 1'b0;
            mul.start <= 1'b0;
            red.start <= 1'b0;
            done      <= 1'b0;
            x_out     <= '0;
            z_out     <= '0;
        end else begin
            mul.start <= 1'b0;
            red.start <= 1'b0;
            done      <= 1'b0;
            if (mul.done) begin
                mul_seen <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        x_q   <= x_in;
                        z_q   <= z_in;
                        state <= S_SUM;
                    end
                end
                // s*s
                S_SUM: begin
                    mul.a     <= as.result;
                    mul.b     <= as.result;
                    mul.start <= 1'b1;
                    mul_seen  <= 1'b0;
                    state     <= S_SS_MUL;
                end
                // Reduce s*s, multiply d*d meanwhile
                S_SS_MUL: begin
                    if (mul_ready) begin
                        red.value <= mul.product;
                        red.start <= 1'b1;
                        mul.a     <= as.result;
                        mul.b     <= as.result;
                        mul.start <= 1'b1;
                        mul_seen  <= 1'b0;
                        state     <= S_SS_RED;
                    end
                end
                S_SS_RED: begin
                    if (red.done) begin
                        ss    <= red.result;
                        state <= S_DD_MUL;
                    end
                end
                S_DD_MUL: begin
                    if (mul_ready) begin
                        red.value <= mul.product;
                        red.start <= 1'b1;
                        state     <= S_DD_RED;
                    end
                end
                // ss*dd gives X2
                S_DD_RED: begin
                    if (red.done) begin
                        dd        <= red.result;
                        mul.a     <= ss;
                        mul.b     <= red.result;
                        mul.start <= 1'b1;
                        mul_seen  <= 1'b0;
                        state     <= S_T;
                    end
                end
                S_T: begin
                    t     <= as.result;
                    state <= S_X_MUL;
                end
                S_X_MUL: begin
                    if (mul_ready) begin
                        red.value <= mul.product;
                        red.start <= 1'b1;
                        mul.a     <= t;
                        mul.b     <= x25519_pkg::A24;
                        mul.start <= 1'b1;
                        mul_seen  <= 1'b0;
                        state     <= S_X_RED;
                    end
                end
                S_X_RED: begin
                    if (red.done) begin
                        x_res <= red.result;
                        state <= S_U_MUL;
                    end
                end
                S_U_MUL: begin
                    if (mul_ready) begin
                        red.value <= mul.product;
                        red.start <= 1'b1;
                        state     <= S_U_RED;
                    end
                end
                // (u + dd) * t
                S_U_RED: begin
                    if (red.done) begin
                        mul.a     <= as.result;
                        mul.b     <= t;
                        mul.start <= 1'b1;
                        mul_seen  <= 1'b0;
                        state     <= S_Z_MUL;
                    end
                end
                S_Z_MUL: begin
                    if (mul_ready) begin
                        red.value <= mul.product;
                        red.start <= 1'b1;
                        state     <= S_Z_RED;
                    end
                end
                S_Z_RED: begin
                    if (red.done) begin
                        x_out <= x_res;
                        z_out <= red.result;
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/ladder_dbl.sv
`timescale 1ns/1ps

module ladder_dbl #(
    parameter int DIGIT_W = 5
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  x25519_pkg::felem_t x_in,
    input  x25519_pkg::felem_t z_in,
    output x25519_pkg::felem_t x_out,
    output x25519_pkg::felem_t z_out,
    output logic               done,
    output logic               busy
);

    mul_if    mul_bus ();
    red_if    red_bus ();
    addsub_if as_bus ();

    ladder_dbl_ctrl ctrl_i (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .x_in  (x_in),
        .z_in  (z_in),
        .x_out (x_out),
        .z_out (z_out),
        .done  (done),
        .busy  (busy),
        .mul   (mul_bus.ctrl),
        .red   (red_bus.ctrl),
        .as    (as_bus.ctrl)
    );

    field_mul #(
        .DIGIT_W (DIGIT_W)
    ) mul_i (
        .clk   (clk),
        .reset (reset),
        .mul   (mul_bus.target)
    );

    field_reduce red_i (
        .clk   (clk),
        .reset (reset),
        .red   (red_bus.target)
    );

    field_addsub as_i (
        .as (as_bus.target)
    );

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: dv/ladder_dbl_assert.sv
`timescale 1ns/1ps

module ladder_dbl_assert (
    input logic         clk,
    input logic         reset,
    input logic         done,
    input logic         busy,
    input logic [254:0] x_out,
    input logic [254:0] z_out
);

    int fail_count = 0;

    // Completion is a single-cycle pulse
    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            fail_count++;
            $error("done held high for two cycles");
        end

    busy_reset: assert property (@(posedge clk) reset |=> !busy)
        else begin
            fail_count++;
            $error("busy high after a reset cycle");
        end

    // Results only move with done
    out_stable: assert property (@(posedge clk) disable iff (reset)
                                 !done |-> ($stable(x_out) && $stable(z_out)))
        else begin
            fail_count++;
            $error("x_out or z_out changed without done");
        end

endmodule

bind ladder_dbl ladder_dbl_assert assert_i (
    .clk   (clk),
    .reset (reset),
    .done  (done),
    .busy  (busy),
    .x_out (x_out),
    .z_out (z_out)
);

// File: dv/tb_ladder_dbl.sv
`timescale 1ns/1ps

module tb_ladder_dbl;

    // 13 doubling steps at roughly 400 cycles each, plus margin
    localparam int N_OPS      = 13;
    localparam int OP_CYCLES  = 400;
    localparam int MAX_CYCLES = N_OPS * OP_CYCLES + 800;

    logic         clk;
    logic         reset;
    logic         start;
    logic [254:0] x_in;
    logic [254:0] z_in;
    logic [254:0] x_out;
    logic [254:0] z_out;
    logic         done;
    logic         busy;

    int           errors   = 0;
    int           cycles   = 0;
    int           done_cnt = 0;
    integer       seed;
    logic [511:0] p_wide;
    logic [254:0] p;

    clk_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (10)
    ) clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    ladder_dbl dut_i (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .x_in  (x_in),
        .z_in  (z_in),
        .x_out (x_out),
        .z_out (z_out),
        .done  (done),
        .busy  (busy)
    );

    always @(posedge clk) begin
        if (done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no result after %0d cycles, run stopped", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ============================================================
    // Reference model and helpers
    // ============================================================
    task automatic model_dbl(input logic [254:0] x, input logic [254:0] z,
                             output logic [254:0] x2, output logic [254:0] z2);
        logic [511:0] s;
        logic [511:0] d;
        logic [511:0] ss;
        logic [511:0] dd;
        logic [511:0] t;
        logic [511:0] u;
        logic [511:0] r;
        s  = (512'(x) + 512'(z)) % p_wide;
        d  = (512'(x) + p_wide - 512'(z)) % p_wide;
        ss = (s * s) % p_wide;
        dd = (d * d) % p_wide;
        t  = (ss + p_wide - dd) % p_wide;
        u  = (t * 512'd121666) % p_wide;
        r  = (dd + u) % p_wide;
        x2 = 255'((ss * dd) % p_wide);
        z2 = 255'((t * r) % p_wide);
    endtask

    task automatic check(input string name, input logic [254:0] expected,
                         input logic [254:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic rand_felem(output logic [254:0] v);
        logic [255:0] raw;
        for (int i = 0; i < 8; i++) begin
            raw[i*32 +: 32] = $random(seed);
        end
        v = raw[254:0];
        if (v >= p) begin
            v = v - p;
        end
    endtask

    task automatic pulse_start(input logic [254:0] x, input logic [254:0] z);
        @(posedge clk);
        start <= 1'b1;
        x_in  <= x;
        z_in  <= z;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Completion pulse, sampled mid-cycle
    task automatic wait_done();
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic test_reset();
        @(negedge clk);
        while (reset !== 1'b0) begin
            @(negedge clk);
        end
        check("reset busy", 255'd0, 255'(busy));
        check("reset done", 255'd0, 255'(done));
        check("reset x_out", 255'd0, x_out);
        check("reset z_out", 255'd0, z_out);
    endtask

    task automatic test_dbl(input string name, input logic [254:0] x, input logic [254:0] z);
        logic [254:0] x2;
        logic [254:0] z2;
        int           cnt0;
        model_dbl(x, z, x2, z2);
        cnt0 = done_cnt;
        pulse_start(x, z);
        wait_done();
        check({name, " x2"}, x2, x_out);
        check({name, " z2"}, z2, z_out);
        check({name, " busy"}, 255'd0, 255'(busy));
        repeat (4) @(negedge clk);
        check({name, " done pulses"}, 255'd1, 255'(done_cnt - cnt0));
    endtask

    task automatic test_busy_start();
        logic [254:0] x1;
        logic [254:0] z1;
        logic [254:0] xb;
        logic [254:0] zb;
        logic [254:0] x2;
        logic [254:0] z2;
        int           cnt0;
        rand_felem(x1);
        rand_felem(z1);
        rand_felem(xb);
        rand_felem(zb);
        model_dbl(x1, z1, x2, z2);
        cnt0 = done_cnt;
        pulse_start(x1, z1);
        repeat (20) @(negedge clk);
        check("busy start busy", 255'd1, 255'(busy));
        // Second request lands mid-operation
        pulse_start(xb, zb);
        wait_done();
        check("busy start x2", x2, x_out);
        check("busy start z2", z2, z_out);
        check("busy start busy after done", 255'd0, 255'(busy));
        repeat (4) @(negedge clk);
        check("busy start done pulses", 255'd1, 255'(done_cnt - cnt0));
        check("busy start idle", 255'd0, 255'(busy));
    endtask

    initial begin
        logic [254:0] xr;
        logic [254:0] zr;
        int           total;
        start  = 1'b0;
        x_in   = '0;
        z_in   = '0;
        seed   = 32'ha86d;
        p_wide = (512'd1 << 255) - 512'd19;
        p      = p_wide[254:0];

        test_reset();
        test_dbl("known point", 255'd9, 255'd1);
        for (int i = 0; i < 8; i++) begin
            rand_felem(xr);
            rand_felem(zr);
            test_dbl($sformatf("random %0d", i), xr, zr);
        end
        test_dbl("edge 0 1", 255'd0, 255'd1);
        test_dbl("edge p-1 p-1", p - 255'd1, p - 255'd1);
        test_dbl("edge 1 p-1", 255'd1, p - 255'd1);
        test_busy_start();

        total = errors + dut_i.assert_i.fail_count;
        $display("check errors: %0d, assertion errors: %0d", errors, dut_i.assert_i.fail_count);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
hdl/x25519_pkg.sv
hdl/field_if.sv
hdl/field_mul.sv
hdl/field_reduce.sv
hdl/field_addsub.sv
hdl/ladder_dbl_ctrl.sv
hdl/ladder_dbl.sv
dv/clk_gen.sv
dv/ladder_dbl_assert.sv
dv/tb_ladder_dbl.sv

// File: run.sh
#!/bin/sh
# Build and run the ladder doubling testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_ladder_dbl \
    -f tb.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
